/* verilog/stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  // Electrical phase, 256 microsteps per cycle
  localparam int PHASE_W = 8;
  localparam int QUARTER = 1 << (PHASE_W - 2);

  // Cosine table index runs 0..QUARTER
  localparam int INDEX_W = 7;

  // PWM counter and current magnitude
  localparam int PWM_W = 8;

  // Chopper timing in clocks
  localparam int BLANK_TIME  = 27;
  localparam int MIN_ON_TIME = 64;
  localparam int OFF_TIME    = 810;
  localparam int FAST_TIME   = 104;

  localparam int BLANK_W  = $clog2(BLANK_TIME + 1);
  localparam int MIN_ON_W = $clog2(MIN_ON_TIME + 1);
  localparam int OFF_W    = $clog2(OFF_TIME);

  // Charge pump toggles every half period
  localparam int CP_HALF_PERIOD = 8;
  localparam int CP_W           = $clog2(CP_HALF_PERIOD);

  typedef enum logic [2:0] {
    CHOP_OFF,
    CHOP_DRIVE,
    CHOP_FAST,
    CHOP_SLOW,
    CHOP_FAULT
  } chop_state_t;

endpackage

`default_nettype wire

/* verilog/microstep_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module microstep_sequencer import stepper_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               step,
  input  logic               dir,
  output logic [INDEX_W-1:0] index_a,
  output logic [INDEX_W-1:0] index_b,
  output logic               polarity_a,
  output logic               polarity_b
);

  logic [2:0]         step_sync;
  logic [1:0]         dir_sync;
  logic               step_rise;
  logic [PHASE_W-1:0] phase;
  logic [1:0]         quad;
  logic [INDEX_W-1:0] offset;
  logic [INDEX_W-1:0] next_index_a;

  // Two-flop synchronizers, third step flop for edge detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step_sync <= '0;
      dir_sync  <= '0;
    end else begin
      step_sync <= {step_sync[1:0], step};
      dir_sync  <= {dir_sync[0], dir};
    end
  end

  assign step_rise = step_sync[1] & ~step_sync[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (step_rise) begin
      phase <= dir_sync[1] ? phase + 1'b1 : phase - 1'b1;
    end
  end

  // Quadrant folding onto the quarter-wave table
  assign quad         = phase[PHASE_W-1 -: 2];
  assign offset       = INDEX_W'(phase[PHASE_W-3:0]);
  assign next_index_a = quad[0] ? INDEX_W'(QUARTER) - offset : offset;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      index_a    <= '0;
      index_b    <= INDEX_W'(QUARTER);
      polarity_a <= 1'b1;
      polarity_b <= 1'b1;
    end else begin
      index_a    <= next_index_a;
      index_b    <= INDEX_W'(QUARTER) - next_index_a;
      polarity_a <= (quad[1] == quad[0]);
      polarity_b <= ~quad[1];
    end
  end

endmodule

`default_nettype wire

/* verilog/cosine_table.sv */
`timescale 1ns/1ns
`default_nettype none

module cosine_table import stepper_pkg::*; (
  input  logic [INDEX_W-1:0] index,
  output logic [PWM_W-1:0]   magnitude
);

  // 255 * cos(pi * i / 128), rounded
  always_comb begin
    case (index)
      7'd0:    magnitude = 8'd255;
      7'd1:    magnitude = 8'd255;
      7'd2:    magnitude = 8'd255;
      7'd3:    magnitude = 8'd254;
      7'd4:    magnitude = 8'd254;
      7'd5:    magnitude = 8'd253;
      7'd6:    magnitude = 8'd252;
      7'd7:    magnitude = 8'd251;
      7'd8:    magnitude = 8'd250;
      7'd9:    magnitude = 8'd249;
      7'd10:   magnitude = 8'd247;
      7'd11:   magnitude = 8'd246;
      7'd12:   magnitude = 8'd244;
      7'd13:   magnitude = 8'd242;
      7'd14:   magnitude = 8'd240;
      7'd15:   magnitude = 8'd238;
      7'd16:   magnitude = 8'd236;
      7'd17:   magnitude = 8'd233;
      7'd18:   magnitude = 8'd231;
      7'd19:   magnitude = 8'd228;
      7'd20:   magnitude = 8'd225;
      7'd21:   magnitude = 8'd222;
      7'd22:   magnitude = 8'd219;
      7'd23:   magnitude = 8'd215;
      7'd24:   magnitude = 8'd212;
      7'd25:   magnitude = 8'd208;
      7'd26:   magnitude = 8'd205;
      7'd27:   magnitude = 8'd201;
      7'd28:   magnitude = 8'd197;
      7'd29:   magnitude = 8'd193;
      7'd30:   magnitude = 8'd189;
      7'd31:   magnitude = 8'd185;
      7'd32:   magnitude = 8'd180;
      7'd33:   magnitude = 8'd176;
      7'd34:   magnitude = 8'd171;
      7'd35:   magnitude = 8'd167;
      7'd36:   magnitude = 8'd162;
      7'd37:   magnitude = 8'd157;
      7'd38:   magnitude = 8'd152;
      7'd39:   magnitude = 8'd147;
      7'd40:   magnitude = 8'd142;
      7'd41:   magnitude = 8'd136;
      7'd42:   magnitude = 8'd131;
      7'd43:   magnitude = 8'd126;
      7'd44:   magnitude = 8'd120;
      7'd45:   magnitude = 8'd115;
      7'd46:   magnitude = 8'd109;
      7'd47:   magnitude = 8'd103;
      7'd48:   magnitude = 8'd98;
      7'd49:   magnitude = 8'd92;
      7'd50:   magnitude = 8'd86;
      7'd51:   magnitude = 8'd80;
      7'd52:   magnitude = 8'd74;
      7'd53:   magnitude = 8'd68;
      7'd54:   magnitude = 8'd62;
      7'd55:   magnitude = 8'd56;
      7'd56:   magnitude = 8'd50;
      7'd57:   magnitude = 8'd44;
      7'd58:   magnitude = 8'd37;
      7'd59:   magnitude = 8'd31;
      7'd60:   magnitude = 8'd25;
      7'd61:   magnitude = 8'd19;
      7'd62:   magnitude = 8'd13;
      7'd63:   magnitude = 8'd6;
      // Entry 64 and any out-of-range index give zero current
      default: magnitude = 8'd0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/current_dac.sv */
`timescale 1ns/1ns
`default_nettype none

module current_dac import stepper_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [PWM_W-1:0] level_a,
  input  logic [PWM_W-1:0] level_b,
  output logic             analog_out1,
  output logic             analog_out2
);

  logic [PWM_W-1:0] pwm_cnt;
  logic [PWM_W-1:0] held_a;
  logic [PWM_W-1:0] held_b;
  logic             wrap;

  assign wrap = (pwm_cnt == '1);

  // Levels reload only at the period boundary
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
      held_a  <= '0;
      held_b  <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (wrap) begin
        held_a <= level_a;
        held_b <= level_b;
      end
    end
  end

  // Registered compare keeps the pins free of decode glitches
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      analog_out1 <= 1'b0;
      analog_out2 <= 1'b0;
    end else begin
      analog_out1 <= (pwm_cnt < held_a);
      analog_out2 <= (pwm_cnt < held_b);
    end
  end

endmodule

`default_nettype wire

/* verilog/chopper_channel.sv */
`timescale 1ns/1ns
`default_nettype none

module chopper_channel import stepper_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable,
  input  logic       polarity,
  input  logic       cmp,
  output logic [1:0] bridge_h,
  output logic [1:0] bridge_l,
  output logic       fault
);

  chop_state_t         state;
  chop_state_t         state_next;
  logic [BLANK_W-1:0]  blank_cnt;
  logic [MIN_ON_W-1:0] min_on_cnt;
  logic [OFF_W-1:0]    off_cnt;
  logic                pol_q;
  logic                drive_start;
  logic                trip;

  // Enable rise or a polarity flip while driving
  assign drive_start = enable &&
                       ((state == CHOP_OFF) || (state == CHOP_DRIVE && polarity != pol_q));

  // Comparator only counts once blanking is over
  assign trip = (state == CHOP_DRIVE) && !drive_start && cmp && (blank_cnt == '0);

  always_comb begin
    state_next = state;
    if (!enable) begin
      state_next = CHOP_OFF;
    end else begin
      case (state)
        CHOP_OFF:   state_next = CHOP_DRIVE;
        CHOP_DRIVE: begin
          if (trip) begin
            state_next = (min_on_cnt != '0) ? CHOP_FAULT : CHOP_FAST;
          end
        end
        CHOP_FAST: begin
          if (off_cnt == OFF_W'(OFF_TIME - FAST_TIME)) begin
            state_next = CHOP_SLOW;
          end
        end
        CHOP_SLOW: begin
          if (off_cnt == '0) begin
            state_next = CHOP_DRIVE;
          end
        end
        // Fault holds until enable drops
        default:    state_next = state;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= CHOP_OFF;
      blank_cnt  <= '0;
      min_on_cnt <= '0;
      off_cnt    <= '0;
      pol_q      <= 1'b0;
    end else begin
      state <= state_next;
      pol_q <= polarity;
      if (drive_start) begin
        blank_cnt  <= BLANK_W'(BLANK_TIME);
        min_on_cnt <= MIN_ON_W'(MIN_ON_TIME);
      end else begin
        if (blank_cnt != '0) blank_cnt <= blank_cnt - 1'b1;
        if (min_on_cnt != '0) min_on_cnt <= min_on_cnt - 1'b1;
      end
      // Off period counts down from the trip
      if (trip) begin
        off_cnt <= OFF_W'(OFF_TIME - 1);
      end else if (off_cnt != '0) begin
        off_cnt <= off_cnt - 1'b1;
      end
    end
  end

  // Gate decode, half 1 in bit 0
  always_comb begin
    bridge_h = 2'b00;
    bridge_l = 2'b00;
    case (state)
      CHOP_DRIVE: begin
        bridge_h = polarity ? 2'b01 : 2'b10;
        bridge_l = polarity ? 2'b10 : 2'b01;
      end
      CHOP_FAST: begin
        bridge_h = polarity ? 2'b10 : 2'b01;
        bridge_l = polarity ? 2'b01 : 2'b10;
      end
      CHOP_SLOW:  bridge_l = 2'b11;
      default:    bridge_h = 2'b00;
    endcase
  end

  assign fault = (state == CHOP_FAULT);

endmodule

`default_nettype wire

/* verilog/charge_pump_osc.sv */
`timescale 1ns/1ns
`default_nettype none

module charge_pump_osc import stepper_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  output logic chargepump_pin
);

  logic [CP_W-1:0] div_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt        <= '0;
      chargepump_pin <= 1'b0;
    end else if (div_cnt == CP_W'(CP_HALF_PERIOD - 1)) begin
      div_cnt        <= '0;
      chargepump_pin <= ~chargepump_pin;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/microstepper_top.sv */
`timescale 1ns/1ns
`default_nettype none

module microstepper_top import stepper_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       step,
  input  wire       dir,
  input  wire       enable,
  input  wire       analog_cmp1,
  input  wire       analog_cmp2,
  output wire [3:0] s_h,
  output wire [3:0] s_l,
  output wire       analog_out1,
  output wire       analog_out2,
  output wire       chargepump_pin,
  output wire [1:0] fault
);

  wire [INDEX_W-1:0] index_a;
  wire [INDEX_W-1:0] index_b;
  wire               polarity_a;
  wire               polarity_b;
  wire [PWM_W-1:0]   level_a;
  wire [PWM_W-1:0]   level_b;

  microstep_sequencer seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .step       (step),
    .dir        (dir),
    .index_a    (index_a),
    .index_b    (index_b),
    .polarity_a (polarity_a),
    .polarity_b (polarity_b)
  );

  cosine_table cos_a (.index(index_a), .magnitude(level_a));
  cosine_table cos_b (.index(index_b), .magnitude(level_b));

  current_dac dac (
    .clk         (clk),
    .rst_n       (rst_n),
    .level_a     (level_a),
    .level_b     (level_b),
    .analog_out1 (analog_out1),
    .analog_out2 (analog_out2)
  );

  // Coil A on bridge bits 1:0, coil B on bits 3:2
  chopper_channel chop_a (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .polarity (polarity_a),
    .cmp      (analog_cmp1),
    .bridge_h (s_h[1:0]),
    .bridge_l (s_l[1:0]),
    .fault    (fault[0])
  );

  chopper_channel chop_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .polarity (polarity_b),
    .cmp      (analog_cmp2),
    .bridge_h (s_h[3:2]),
    .bridge_l (s_l[3:2]),
    .fault    (fault[1])
  );

  charge_pump_osc cp (.clk(clk), .rst_n(rst_n), .chargepump_pin(chargepump_pin));

endmodule

`default_nettype wire

/* dv/microstepper_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module microstepper_properties import stepper_pkg::*; (
  input wire       clk,
  input wire       rst_n,
  input wire       enable,
  input wire [3:0] s_h,
  input wire [3:0] s_l,
  input wire [1:0] fault,
  input wire       chargepump_pin
);

  int         fail_count = 0;
  logic       cp_q;
  logic       cp_seen;
  logic [3:0] stable_cnt;

  // Clocks since the last charge pump edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cp_q       <= 1'b0;
      cp_seen    <= 1'b0;
      stable_cnt <= '0;
    end else begin
      cp_q <= chargepump_pin;
      if (chargepump_pin != cp_q) begin
        stable_cnt <= '0;
        cp_seen    <= 1'b1;
      end else if (stable_cnt != '1) begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

  no_shoot_through: assert property (@(posedge clk) disable iff (!rst_n)
    (s_h & s_l) == 4'b0000)
    else begin
      fail_count++;
      $error("High and low switch of one half-bridge on together");
    end

  fault_a_off: assert property (@(posedge clk) disable iff (!rst_n)
    fault[0] |-> (s_h[1:0] == 2'b00 && s_l[1:0] == 2'b00))
    else begin
      fail_count++;
      $error("Coil A gates active while its fault is set");
    end

  fault_b_off: assert property (@(posedge clk) disable iff (!rst_n)
    fault[1] |-> (s_h[3:2] == 2'b00 && s_l[3:2] == 2'b00))
    else begin
      fail_count++;
      $error("Coil B gates active while its fault is set");
    end

  disable_off: assert property (@(posedge clk) disable iff (!rst_n)
    !enable |=> (s_h == 4'b0000 && s_l == 4'b0000))
    else begin
      fail_count++;
      $error("Gates still active one clock after enable went low");
    end

  cp_half_period: assert property (@(posedge clk) disable iff (!rst_n)
    (cp_seen && chargepump_pin != cp_q) |-> stable_cnt == 4'(CP_HALF_PERIOD - 1))
    else begin
      fail_count++;
      $error("Charge pump toggled before its half period ended");
    end

endmodule

bind microstepper_top microstepper_properties props (
  .clk            (clk),
  .rst_n          (rst_n),
  .enable         (enable),
  .s_h            (s_h),
  .s_l            (s_l),
  .fault          (fault),
  .chargepump_pin (chargepump_pin)
);

`default_nettype wire

/* include/tb_defs.svh */
`ifndef TB_DEFS_SVH
`define TB_DEFS_SVH

localparam logic [31:0] SEED = 32'hb748_44c6;
// About 9k cycles of tests, generous margin on top
localparam int TIMEOUT_CYCLES = 120000;
// Stepping rounds, each closed by one PWM measurement
localparam int MEAS_PERIODS = 8;
localparam int CP_PERIODS = 4;

`endif

/* dv/microstepper_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module microstepper_tb import stepper_pkg::*; ();

  `include "tb_defs.svh"

  localparam real PI = 3.14159265358979;

  logic               clk;
  logic               rst_n;
  logic               step;
  logic               dir;
  logic               enable;
  logic               analog_cmp1;
  logic               analog_cmp2;
  wire  [3:0]         s_h;
  wire  [3:0]         s_l;
  wire                analog_out1;
  wire                analog_out2;
  wire                chargepump_pin;
  wire  [1:0]         fault;
  logic [PHASE_W-1:0] phase;
  int                 checks = 0;
  int                 errors = 0;
  int                 cycles = 0;

  microstepper_top DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .step           (step),
    .dir            (dir),
    .enable         (enable),
    .analog_cmp1    (analog_cmp1),
    .analog_cmp2    (analog_cmp2),
    .s_h            (s_h),
    .s_l            (s_l),
    .analog_out1    (analog_out1),
    .analog_out2    (analog_out2),
    .chargepump_pin (chargepump_pin),
    .fault          (fault)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // Reference model of the quadrant folding and the cosine table
  function automatic int coil_index(input logic [PHASE_W-1:0] ph, input int coil);
    int q;
    int o;
    int ia;
    q  = int'(ph) / 64;
    o  = int'(ph) % 64;
    ia = (q % 2 == 0) ? o : 64 - o;
    return (coil == 0) ? ia : 64 - ia;
  endfunction

  function automatic int expected_level(input int idx);
    return $rtoi($floor(255.0 * $cos(PI * real'(idx) / 128.0) + 0.5));
  endfunction

  function automatic logic expected_pol(input logic [PHASE_W-1:0] ph, input int coil);
    int q;
    q = int'(ph) / 64;
    return (coil == 0) ? (q == 0 || q == 3) : (q == 0 || q == 1);
  endfunction

  // Gates as {high[2:1], low[2:1]} of one coil
  function automatic logic [3:0] drive_pattern(input logic pol);
    return pol ? 4'b0110 : 4'b1001;
  endfunction

  function automatic logic [3:0] coil_gates(input int coil);
    return (coil == 0) ? {s_h[1:0], s_l[1:0]} : {s_h[3:2], s_l[3:2]};
  endfunction

  task automatic step_once(input logic up);
    dir = up;
    @(negedge clk);
    step = 1'b1;
    repeat (2) @(negedge clk);
    step = 1'b0;
    repeat (2) @(negedge clk);
    phase = up ? phase + 8'd1 : phase - 8'd1;
  endtask

  task automatic check_outputs(output int high1, output int high2);
    int exp1;
    int exp2;
    high1 = 0;
    high2 = 0;
    // Two PWM periods let the new levels through the reload
    repeat (512) @(negedge clk);
    repeat (256) begin
      @(negedge clk);
      if (analog_out1) high1++;
      if (analog_out2) high2++;
    end
    exp1 = expected_level(coil_index(phase, 0));
    exp2 = expected_level(coil_index(phase, 1));
    check(high1 == exp1, $sformatf("phase %0d coil A current %0d, expected %0d",
                                   phase, high1, exp1));
    check(high2 == exp2, $sformatf("phase %0d coil B current %0d, expected %0d",
                                   phase, high2, exp2));
    check(coil_gates(0) == drive_pattern(expected_pol(phase, 0)),
          $sformatf("phase %0d coil A gates %b", phase, coil_gates(0)));
    check(coil_gates(1) == drive_pattern(expected_pol(phase, 1)),
          $sformatf("phase %0d coil B gates %b", phase, coil_gates(1)));
  endtask

  task automatic reset_idle_test();
    int   edges;
    int   count;
    logic last;
    check(s_h == 4'b0 && s_l == 4'b0 && fault == 2'b0, "gates or fault active after reset");
    check(!analog_out1 && !analog_out2, "analog outputs active after reset");
    edges = 0;
    count = 0;
    last  = chargepump_pin;
    while (edges <= CP_PERIODS) begin
      @(negedge clk);
      count++;
      if (chargepump_pin && !last) begin
        if (edges > 0) begin
          check(count == 2 * CP_HALF_PERIOD,
                $sformatf("charge pump period %0d clocks", count));
        end
        edges++;
        count = 0;
      end
      last = chargepump_pin;
    end
  endtask

  task automatic stepping_test();
    int   n;
    logic up;
    int   h1;
    int   h2;
    int   r1;
    int   r2;
    enable = 1'b1;
    repeat (MEAS_PERIODS) begin
      n  = int'($urandom_range(40, 1));
      up = ($urandom % 2) == 1;
      repeat (n) step_once(up);
      check_outputs(h1, h2);
    end
    n = int'($urandom_range(40, 1));
    repeat (n) step_once(1'b1);
    repeat (n) step_once(1'b0);
    check_outputs(r1, r2);
    check(r1 == h1 && r2 == h2, $sformatf("currents %0d/%0d after %0d steps out and back",
                                          r1, r2, n));
  endtask

  task automatic chopping_test();
    logic       pol;
    logic [3:0] b_gates;
    int         fast_cnt;
    int         slow_cnt;
    pol = expected_pol(phase, 0);
    while (expected_pol(phase, 0) == pol) step_once(1'b1);
    pol = expected_pol(phase, 0);
    repeat (MIN_ON_TIME + 8) @(negedge clk);
    b_gates     = coil_gates(1);
    analog_cmp1 = 1'b1;
    @(negedge clk);
    analog_cmp1 = 1'b0;
    fast_cnt    = 0;
    slow_cnt    = 0;
    while (coil_gates(0) == drive_pattern(!pol) && fast_cnt <= OFF_TIME) begin
      check(coil_gates(1) == b_gates, "coil B changed during coil A fast decay");
      fast_cnt++;
      @(negedge clk);
    end
    while (coil_gates(0) == 4'b0011 && slow_cnt <= OFF_TIME) begin
      check(coil_gates(1) == b_gates, "coil B changed during coil A slow decay");
      slow_cnt++;
      @(negedge clk);
    end
    check(fast_cnt == FAST_TIME, $sformatf("fast decay %0d cycles, expected %0d",
                                           fast_cnt, FAST_TIME));
    check(slow_cnt == OFF_TIME - FAST_TIME, $sformatf("slow decay %0d cycles, expected %0d",
                                                      slow_cnt, OFF_TIME - FAST_TIME));
    check(coil_gates(0) == drive_pattern(pol), "coil A did not return to drive");
    check(coil_gates(1) == b_gates, "coil B changed after coil A chopping");
  endtask

  task automatic fault_test();
    logic pol;
    pol = expected_pol(phase, 1);
    while (expected_pol(phase, 1) == pol) step_once(1'b1);
    // Comparator high only inside the blanking window
    analog_cmp2 = 1'b1;
    repeat (BLANK_TIME - 7) begin
      @(negedge clk);
      check(coil_gates(1) == drive_pattern(!pol), "coil B left drive during blanking");
    end
    analog_cmp2 = 1'b0;
    step_once(1'b0);
    repeat ((BLANK_TIME + MIN_ON_TIME) / 2) @(negedge clk);
    analog_cmp2 = 1'b1;
    @(negedge clk);
    analog_cmp2 = 1'b0;
    check(fault == 2'b10, $sformatf("fault %b after early coil B trip", fault));
    check(coil_gates(1) == 4'b0000, "coil B gates active in fault");
    check(coil_gates(0) == drive_pattern(expected_pol(phase, 0)), "coil A stopped driving");
    repeat (20) @(negedge clk);
    check(fault == 2'b10, "coil B fault did not stay latched");
    enable = 1'b0;
    @(negedge clk);
    check(fault == 2'b00 && s_h == 4'b0 && s_l == 4'b0, "fault or gates left after disable");
    enable = 1'b1;
    @(negedge clk);
    check(fault == 2'b00, "fault set again after enable");
    check(coil_gates(1) == drive_pattern(expected_pol(phase, 1)), "coil B not driving again");
  endtask

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    step        = 1'b0;
    dir         = 1'b0;
    enable      = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    phase       = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_idle_test();
    stepping_test();
    chopping_test();
    fault_test();
    errors += DUT.props.fail_count;
    $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
             checks, errors, DUT.props.fail_count);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
verilog/stepper_pkg.sv
verilog/microstep_sequencer.sv
verilog/cosine_table.sv
verilog/current_dac.sv
verilog/chopper_channel.sv
verilog/charge_pump_osc.sv
verilog/microstepper_top.sv
dv/microstepper_properties.sv
dv/microstepper_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the microstepper testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f \
    --top-module microstepper_tb -o microstepper_sim; then
  echo "Verilator build failed"
  exit 1
fi

# Raised error limit lets the testbench reach its own summary
output="$(./obj_dir/microstepper_sim +verilator+error+limit+100)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "All tests passed!"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
